// File: build.f
logic/exu_ctl_pkg.sv
logic/exu_mem_pkg.sv
logic/key_mux.sv
logic/adder32.sv
logic/alu.sv
logic/lsu_align.sv
logic/data_mem.sv
logic/exu.sv
logic/exu_top.sv
sim/exu_tb.sv

// File: Bender.yml
package:
  name: exu_stage

sources:
  - logic/exu_ctl_pkg.sv
  - logic/exu_mem_pkg.sv
  - logic/key_mux.sv
  - logic/adder32.sv
  - logic/alu.sv
  - logic/lsu_align.sv
  - logic/data_mem.sv
  - logic/exu.sv
  - logic/exu_top.sv
  - target: simulation
    files:
      - sim/exu_tb.sv

// File: sim/exu_vectors.txt
# id opt rs1_d rs2_d imm pc exp_rd_d exp_dnpc exp_halt exp_halt_code flags, all hex
# flags bit 0 compares rd_d, flags bit 1 resets the DUT before the vector
01 0110 00000005 00000007 00000000 00001000 0000000c 00001004 0 00000000 1
02 8110 00000005 00000007 00000000 00001000 fffffffe 00001004 0 00000000 1
03 0130 00000003 00000024 00000000 00001000 00000030 00001004 0 00000000 1
04 4150 ffffffff 00000001 00000000 00001000 00000001 00001004 0 00000000 1
05 0150 ffffffff 00000001 00000000 00001000 00000000 00001004 0 00000000 1
06 4150 80000000 00000001 00000000 00001000 00000001 00001004 0 00000000 1
07 0170 00001234 00001234 00000000 00001000 00000001 00001004 0 00000000 1
08 0190 f0f0f0f0 ff00ff00 00000000 00001000 0ff00ff0 00001004 0 00000000 1
09 01b0 80000010 00000004 00000000 00001000 08000001 00001004 0 00000000 1
0a 41b0 80000010 00000004 00000000 00001000 f8000001 00001004 0 00000000 1
0b 01d0 f0f0f0f0 0000ffff 00000000 00001000 f0f0ffff 00001004 0 00000000 1
0c 01f0 f0f0f0f0 0000ffff 00000000 00001000 0000f0f0 00001004 0 00000000 1
0d 0118 00000100 00000000 00000020 00001000 00000120 00001004 0 00000000 1
0e 0100 00000000 00000000 abcde000 00001000 abcde000 00001004 0 00000000 1
0f 0108 00000000 00000000 00000010 00001000 00001010 00001004 0 00000000 1
10 1208 00000000 00000000 00000040 00001000 00001004 00001040 0 00000000 1
11 1308 00002000 00000000 00000008 00001000 00001004 00002008 0 00000000 1
12 0210 00000001 00000002 00000100 00001000 00000003 00001100 0 00000000 1
13 0070 00000005 00000005 00000020 00001000 00000001 00001020 0 00000000 1
14 0070 00000005 00000006 00000020 00001000 00000000 00001004 0 00000000 1
15 8070 00000005 00000006 00000020 00001000 00000001 00001020 0 00000000 1
16 4050 fffffff0 00000010 00000020 00001000 00000001 00001020 0 00000000 1
17 c050 fffffff0 00000010 00000020 00001000 00000000 00001004 0 00000000 1
18 0050 fffffff0 00000010 00000020 00001000 00000000 00001004 0 00000000 1
19 8050 fffffff0 00000010 00000020 00001000 00000001 00001020 0 00000000 1
1a 0d18 00000100 11223344 00000000 00001000 00000000 00001004 0 00000000 0
1b 1d18 00000100 00000000 00000000 00001000 11223344 00001004 0 00000000 1
1c 0518 00000100 000000aa 00000001 00001000 00000000 00001004 0 00000000 0
1d 0518 00000100 00000080 00000003 00001000 00000000 00001004 0 00000000 0
1e 1d18 00000100 00000000 00000000 00001000 8022aa44 00001004 0 00000000 1
1f 0918 00000100 0000beef 00000002 00001000 00000000 00001004 0 00000000 0
20 1d18 00000100 00000000 00000000 00001000 beefaa44 00001004 0 00000000 1
21 0d18 00000104 cafef00d 00000000 00001000 00000000 00001004 0 00000000 0
22 0918 00000104 00001234 00000000 00001000 00000000 00001004 0 00000000 0
23 0518 00000104 000000ff 00000000 00001000 00000000 00001004 0 00000000 0
24 0518 00000104 00000077 00000002 00001000 00000000 00001004 0 00000000 0
25 1d18 00000104 00000000 00000000 00001000 ca7712ff 00001004 0 00000000 1
26 5518 00000100 00000000 00000001 00001000 ffffffaa 00001004 0 00000000 1
27 1518 00000100 00000000 00000001 00001000 000000aa 00001004 0 00000000 1
28 5918 00000100 00000000 00000002 00001000 ffffbeef 00001004 0 00000000 1
29 1918 00000100 00000000 00000002 00001000 0000beef 00001004 0 00000000 1
2a 5518 00000100 00000000 00000000 00001000 00000044 00001004 0 00000000 1
2b 5918 00000104 00000000 00000000 00001000 000012ff 00001004 0 00000000 1
2c 5518 00000104 00000000 00000003 00001000 ffffffca 00001004 0 00000000 1
2d 0000 00000055 00000000 00000000 00001000 00000000 00001004 1 00000009 1
2e 8000 0000002a 00000000 00000000 00001000 00000000 00001004 1 00000009 1
2f 0110 00000001 00000001 00000000 00001000 00000002 00001004 1 00000009 1
30 8000 0000002a 00000000 00000000 00001000 00000000 00001004 1 0000002a 3
31 0000 00000055 00000000 00000000 00001000 00000000 00001004 1 0000002a 1

// File: sim/exu_tb.sv
module exu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    localparam int halt_timeout = 20;

    // size none, add, pc+4 as next pc, never an ebreak
    localparam logic [exu_ctl_pkg::opt_w-1:0] idle_opt = 16'h0100;

    logic                          clk;
    logic                          rst_n;
    logic [exu_ctl_pkg::opt_w-1:0] opt;
    logic [31:0]                   rs1_d;
    logic [31:0]                   rs2_d;
    logic [31:0]                   imm;
    logic [31:0]                   pc;
    logic [31:0]                   rd_d;
    logic [31:0]                   dnpc;
    logic [31:0]                   halt_code;
    logic                          halt;

    logic [31:0] vec_id;
    logic [31:0] vec_opt;
    logic [31:0] vec_rs1;
    logic [31:0] vec_rs2;
    logic [31:0] vec_imm;
    logic [31:0] vec_pc;
    logic [31:0] vec_rd;
    logic [31:0] vec_dnpc;
    logic [31:0] vec_halt;
    logic [31:0] vec_code;
    logic [31:0] vec_flags;

    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int vectors_run  = 0;

    exu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .opt       (opt),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt_code (halt_code),
        .halt      (halt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string label, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", label);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", label, error_count - errors_before);
        end
    endtask

    // halt and halt_code must read zero right after reset is released
    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        #1;
        check_val("halt", {31'd0, halt}, 32'd0);
        check_val("halt_code", halt_code, 32'd0);
    endtask

    task automatic wait_for_halt(output bit seen);
        int cycles;
        seen = 1'b0;
        for (cycles = 0; cycles < halt_timeout && !seen; cycles++) begin
            if (halt === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_vector();
        int errors_before;
        int idle_cycles;
        bit seen;
        errors_before = error_count;
        if (vec_flags[1]) begin
            reset_dut();
        end
        @(posedge clk);
        opt   <= vec_opt[exu_ctl_pkg::opt_w-1:0];
        rs1_d <= vec_rs1;
        rs2_d <= vec_rs2;
        imm   <= vec_imm;
        pc    <= vec_pc;
        // results are combinational, so look just before the closing edge
        #(clk_period - 1);
        if (vec_flags[0]) begin
            check_val("rd_d", rd_d, vec_rd);
        end
        check_val("dnpc", dnpc, vec_dnpc);
        @(posedge clk);
        opt <= idle_opt;
        #1;
        if (vec_halt[0]) begin
            wait_for_halt(seen);
            if (!seen) begin
                $display("test %0h: halt never rose within %0d cycles after the ebreak",
                         vec_id, halt_timeout);
                error_count++;
            end
        end else begin
            check_val("halt", {31'd0, halt}, 32'd0);
        end
        check_val("halt_code", halt_code, vec_code);
        idle_cycles = $urandom_range(3, 0);
        repeat (idle_cycles) @(posedge clk);
        vectors_run++;
        finish_test($sformatf("%0h", vec_id), errors_before);
    endtask

    initial begin
        int    fd;
        int    nread;
        int    fields;
        int    errors_before;
        string line;
        rst_n    = 1'b0;
        opt      = idle_opt;
        rs1_d    = '0;
        rs2_d    = '0;
        imm      = '0;
        pc       = '0;
        void'($urandom(32'h8870));
        fd = $fopen("sim/exu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exu_vectors.txt for reading");
            error_count++;
        end else begin
            errors_before = error_count;
            reset_dut();
            finish_test("reset", errors_before);
            while (!$feof(fd)) begin
                line  = "";
                nread = $fgets(line, fd);
                if (nread > 0 && line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                     vec_id, vec_opt, vec_rs1, vec_rs2, vec_imm, vec_pc,
                                     vec_rd, vec_dnpc, vec_halt, vec_code, vec_flags);
                    if (fields == 11) begin
                        run_vector();
                    end else begin
                        $display("vector file line could not be parsed: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors_run == 0) begin
            $display("no test vectors were run");
        end
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (error_count == 0 && vectors_run > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: logic/exu_top.sv
module exu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [exu_ctl_pkg::opt_w-1:0] opt,
    input  logic [31:0]                   rs1_d,
    input  logic [31:0]                   rs2_d,
    input  logic [31:0]                   imm,
    input  logic [31:0]                   pc,
    output logic [31:0]                   rd_d,
    output logic [31:0]                   dnpc,
    output logic [31:0]                   halt_code,
    output logic                          halt
);

    logic [exu_mem_pkg::mem_aw-1:0] mem_addr;
    logic [31:0]                    mem_wdata;
    logic [exu_mem_pkg::mask_w-1:0] mem_wmask;
    logic [31:0]                    mem_rdata;

    exu u_exu (
        .clk       (clk),
        .rst_n     (rst_n),
        .opt       (opt),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .halt_code (halt_code),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_rdata (mem_rdata)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata)
    );

endmodule

// File: logic/exu.sv
module exu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [exu_ctl_pkg::opt_w-1:0]  opt,
    input  logic [31:0]                    rs1_d,
    input  logic [31:0]                    rs2_d,
    input  logic [31:0]                    imm,
    input  logic [31:0]                    pc,
    output logic [31:0]                    rd_d,
    output logic [31:0]                    dnpc,
    output logic                           halt,
    output logic [31:0]                    halt_code,
    output logic [exu_mem_pkg::mem_aw-1:0] mem_addr,
    output logic [31:0]                    mem_wdata,
    output logic [exu_mem_pkg::mask_w-1:0] mem_wmask,
    input  logic [31:0]                    mem_rdata
);

    logic [1:0]                     opsel;
    logic [2:0]                     alu_op;
    logic [1:0]                     pc_field;
    logic [1:0]                     size;
    logic                           is_load;
    logic                           sign;
    logic                           negate;
    logic                           snpc;
    logic                           is_ebreak;
    logic [1:0]                     pc_ctl;
    logic [1:0]                     op_keys  [4];
    logic [1:0]                     pc_keys  [4];
    logic [63:0]                    op_vals  [4];
    logic [63:0]                    pc_vals  [4];
    logic [63:0]                    operands;
    logic [63:0]                    pc_ops;
    logic [31:0]                    res;
    logic [31:0]                    load_data;
    logic [exu_mem_pkg::mask_w-1:0] lsu_wmask;

    assign opsel    = opt[exu_ctl_pkg::opsel_hi:exu_ctl_pkg::opsel_lo];
    assign alu_op   = opt[exu_ctl_pkg::aluop_hi:exu_ctl_pkg::aluop_lo];
    assign pc_field = opt[exu_ctl_pkg::pcsel_hi:exu_ctl_pkg::pcsel_lo];
    assign size     = opt[exu_ctl_pkg::size_hi:exu_ctl_pkg::size_lo];
    assign is_load  = opt[exu_ctl_pkg::load_bit];
    assign sign     = opt[exu_ctl_pkg::sign_bit];
    assign negate   = opt[exu_ctl_pkg::negate_bit];

    // a load bit with no access size is how jumps are encoded
    assign snpc = (size == exu_mem_pkg::size_none) && is_load;

    // operand pairs are packed as {var1, var2}
    assign op_keys = '{exu_ctl_pkg::opsel_imm, exu_ctl_pkg::opsel_pc_imm,
                       exu_ctl_pkg::opsel_rs1_rs2, exu_ctl_pkg::opsel_rs1_imm};
    assign op_vals = '{{imm, 32'd0}, {pc, imm}, {rs1_d, rs2_d}, {rs1_d, imm}};

    key_mux #(.n_keys(4), .key_w(2), .payload_t(logic [63:0])) u_op_mux (
        .sel    (opsel),
        .keys   (op_keys),
        .values (op_vals),
        .out    (operands)
    );

    alu u_alu (
        .var1   (operands[63:32]),
        .var2   (operands[31:0]),
        .op     (alu_op),
        .snpc   (snpc),
        .sign   (sign),
        .negate (negate),
        .res    (res)
    );

    // a zero pc field means a branch, taken when the compare gave 1
    assign pc_ctl = (pc_field != exu_ctl_pkg::pc_zero) ? pc_field :
                    res[0] ? exu_ctl_pkg::pc_inpc : exu_ctl_pkg::pc_snpc;

    assign pc_keys = '{exu_ctl_pkg::pc_zero, exu_ctl_pkg::pc_snpc,
                       exu_ctl_pkg::pc_inpc, exu_ctl_pkg::pc_reg};
    assign pc_vals = '{64'd0, {pc, 32'd4}, {pc, imm}, {rs1_d, imm}};

    key_mux #(.n_keys(4), .key_w(2), .payload_t(logic [63:0])) u_pc_mux (
        .sel    (pc_ctl),
        .keys   (pc_keys),
        .values (pc_vals),
        .out    (pc_ops)
    );

    adder32 u_pc_adder (
        .ina      (pc_ops[63:32]),
        .inb      (pc_ops[31:0]),
        .sub      (1'b0),
        .sout     (dnpc),
        .cout     (),
        .overflow ()
    );

    lsu_align u_lsu (
        .size       (size),
        .sign       (sign),
        .addr_lo    (res[1:0]),
        .store_data (rs2_d),
        .load_word  (mem_rdata),
        .wmask      (lsu_wmask),
        .wdata      (mem_wdata),
        .load_data  (load_data)
    );

    assign mem_addr  = res[exu_mem_pkg::mem_aw+1:2];
    assign mem_wmask = (size != exu_mem_pkg::size_none && !is_load) ? lsu_wmask : '0;

    assign rd_d = (size == exu_mem_pkg::size_none) ? res : load_data;

    // an all-zero word below the negate bit is the ebreak
    assign is_ebreak = ~|opt[exu_ctl_pkg::negate_bit-1:0];

    // the first ebreak owns the exit code
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt      <= 1'b0;
            halt_code <= 32'd0;
        end else if (is_ebreak && !halt) begin
            halt      <= 1'b1;
            halt_code <= negate ? rs1_d : exu_ctl_pkg::halt_default_code;
        end
    end

    halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halt |=> halt
    ) else $error("exu: halt fell without a reset");

endmodule

// File: logic/data_mem.sv
module data_mem (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [exu_mem_pkg::mem_aw-1:0] addr,
    input  logic [31:0]                    wdata,
    input  logic [exu_mem_pkg::mask_w-1:0] wmask,
    output logic [31:0]                    rdata
);

    logic [31:0] mem [exu_mem_pkg::mem_words];

    // each enabled lane is written at the edge, writes are blocked in reset
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // loads read the array directly in the same cycle
    assign rdata = mem[addr];

    // only four byte lanes exist behind the wide mask
    mask_upper_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        wmask[exu_mem_pkg::mask_w-1:4] == '0
    ) else $error("data_mem: write mask sets a lane above 3, mask %h", wmask);

endmodule

// File: logic/lsu_align.sv
module lsu_align (
    input  logic [1:0]                     size,
    input  logic                           sign,
    input  logic [1:0]                     addr_lo,
    input  logic [31:0]                    store_data,
    input  logic [31:0]                    load_word,
    output logic [exu_mem_pkg::mask_w-1:0] wmask,
    output logic [31:0]                    wdata,
    output logic [31:0]                    load_data
);

    logic [1:0]                     size_keys  [4];
    logic [1:0]                     lane_keys  [4];
    logic [exu_mem_pkg::mask_w-1:0] mask_vals  [4];
    logic [31:0]                    shift_vals [4];
    logic [31:0]                    ext_vals   [4];
    logic [31:0]                    shifted;

    assign size_keys = '{exu_mem_pkg::size_none, exu_mem_pkg::size_byte,
                         exu_mem_pkg::size_half, exu_mem_pkg::size_word};
    assign lane_keys = '{2'd0, 2'd1, 2'd2, 2'd3};

    // a half picks its pair from address bit 1
    assign mask_vals = '{exu_mem_pkg::mask_none,
                         exu_mem_pkg::mask_byte << addr_lo,
                         addr_lo[1] ? exu_mem_pkg::mask_hi_half : exu_mem_pkg::mask_lo_half,
                         exu_mem_pkg::mask_word};

    key_mux #(.n_keys(4), .key_w(2), .payload_t(logic [exu_mem_pkg::mask_w-1:0])) u_mask_mux (
        .sel    (size),
        .keys   (size_keys),
        .values (mask_vals),
        .out    (wmask)
    );

    // store data moves up into the addressed lanes
    assign wdata = store_data << {addr_lo, 3'b000};

    assign shift_vals = '{load_word, load_word >> 8, load_word >> 16, load_word >> 24};

    key_mux #(.n_keys(4), .key_w(2), .payload_t(logic [31:0])) u_lane_mux (
        .sel    (addr_lo),
        .keys   (lane_keys),
        .values (shift_vals),
        .out    (shifted)
    );

    assign ext_vals = '{32'd0,
                        {{24{shifted[7] & sign}}, shifted[7:0]},
                        {{16{shifted[15] & sign}}, shifted[15:0]},
                        shifted};

    key_mux #(.n_keys(4), .key_w(2), .payload_t(logic [31:0])) u_ext_mux (
        .sel    (size),
        .keys   (size_keys),
        .values (ext_vals),
        .out    (load_data)
    );

    // misaligned accesses are not trapped by this stage
    always_comb begin
        if (!$isunknown({size, addr_lo})) begin
            assert final (!((size == exu_mem_pkg::size_half && addr_lo[0]) ||
                            (size == exu_mem_pkg::size_word && addr_lo != 2'd0)))
            else $error("lsu_align: misaligned access, size %0d offset %0d", size, addr_lo);
        end
    end

endmodule

// File: logic/alu.sv
module alu (
    input  logic [31:0] var1,
    input  logic [31:0] var2,
    input  logic [2:0]  op,
    input  logic        snpc,
    input  logic        sign,
    input  logic        negate,
    output logic [31:0] res
);

    logic [31:0] add_b;
    logic        add_sub;
    logic [31:0] sum;
    logic        carry;
    logic        ovf;
    logic        lt;
    logic [4:0]  shamt;
    logic [31:0] sra;

    // compares always subtract, add subtracts only when negated
    assign add_sub = !snpc && ((op == exu_ctl_pkg::alu_slt) ||
                               (op == exu_ctl_pkg::alu_add && negate));

    // the link address reuses the adder with a constant 4
    assign add_b = snpc ? 32'd4 : var2;

    adder32 u_adder (
        .ina      (var1),
        .inb      (add_b),
        .sub      (add_sub),
        .sout     (sum),
        .cout     (carry),
        .overflow (ovf)
    );

    // signed less-than from sign and overflow, unsigned from the borrow
    assign lt = sign ? (sum[31] ^ ovf) : ~carry;

    assign shamt = var2[4:0];
    assign sra   = $signed(var1) >>> shamt;

    always_comb begin
        case (op)
            exu_ctl_pkg::alu_add: res = sum;
            exu_ctl_pkg::alu_sll: res = var1 << shamt;
            // negate turns slt into sge and eq into ne for branches
            exu_ctl_pkg::alu_slt: res = {31'd0, lt ^ negate};
            exu_ctl_pkg::alu_eq:  res = {31'd0, (var1 == var2) ^ negate};
            exu_ctl_pkg::alu_xor: res = var1 ^ var2;
            exu_ctl_pkg::alu_sr:  res = sign ? sra : (var1 >> shamt);
            exu_ctl_pkg::alu_or:  res = var1 | var2;
            exu_ctl_pkg::alu_and: res = var1 & var2;
            default:              res = sum;
        endcase
        if (snpc) begin
            res = sum;
        end
    end

endmodule

// File: logic/adder32.sv
module adder32 (
    input  logic [31:0] ina,
    input  logic [31:0] inb,
    input  logic        sub,
    output logic [31:0] sout,
    output logic        cout,
    output logic        overflow
);

    logic [31:0] inb_x;
    logic [32:0] sum;

    // subtraction is ina + ~inb + 1
    assign inb_x = sub ? ~inb : inb;
    assign sum   = {1'b0, ina} + {1'b0, inb_x} + {32'd0, sub};

    assign sout = sum[31:0];
    // on a subtract, cout set means no borrow, so ina >= inb unsigned
    assign cout = sum[32];

    // signed overflow when both addends agree in sign and the sum does not
    assign overflow = (ina[31] == inb_x[31]) && (sout[31] != ina[31]);

endmodule

// File: logic/key_mux.sv
module key_mux #(
    parameter int  n_keys    = 4,
    parameter int  key_w     = 2,
    parameter type payload_t = logic [31:0]
) (
    input  logic [key_w-1:0] sel,
    input  logic [key_w-1:0] keys   [n_keys],
    input  payload_t         values [n_keys],
    output payload_t         out
);

    logic dup_key;

    // a missing key gives the all-zero payload
    always_comb begin
        out = '0;
        for (int i = 0; i < n_keys; i++) begin
            if (keys[i] == sel) begin
                out = values[i];
            end
        end
    end

    // keys are normally constants, so this only trips on a bad table
    always_comb begin
        dup_key = 1'b0;
        for (int i = 0; i < n_keys; i++) begin
            for (int j = i + 1; j < n_keys; j++) begin
                if (keys[i] == keys[j]) begin
                    dup_key = 1'b1;
                end
            end
        end
    end

    always_comb begin
        assert final (dup_key !== 1'b1) else $error("key_mux: duplicate key in table");
    end

endmodule

// File: logic/exu_mem_pkg.sv
package exu_mem_pkg;

    // data memory geometry, one entry per 32-bit word
    localparam int mem_words = 256;
    localparam int mem_aw    = 8;

    // access size field of the control word
    localparam logic [1:0] size_none = 2'b00;
    localparam logic [1:0] size_byte = 2'b01;
    localparam logic [1:0] size_half = 2'b10;
    localparam logic [1:0] size_word = 2'b11;

    // byte mask is eight bits wide but only lanes 3..0 exist
    localparam int mask_w = 8;

    localparam logic [mask_w-1:0] mask_none    = 8'h00;
    localparam logic [mask_w-1:0] mask_byte    = 8'h01;
    localparam logic [mask_w-1:0] mask_lo_half = 8'h03;
    localparam logic [mask_w-1:0] mask_hi_half = 8'h0c;
    localparam logic [mask_w-1:0] mask_word    = 8'h0f;

endpackage

// File: logic/exu_ctl_pkg.sv
package exu_ctl_pkg;

    // width of the decoded control word
    localparam int opt_w = 16;

    // field positions inside the control word
    localparam int opsel_lo   = 3;
    localparam int opsel_hi   = 4;
    localparam int aluop_lo   = 5;
    localparam int aluop_hi   = 7;
    localparam int pcsel_lo   = 8;
    localparam int pcsel_hi   = 9;
    localparam int size_lo    = 10;
    localparam int size_hi    = 11;
    localparam int load_bit   = 12;
    localparam int sign_bit   = 14;
    // negate also selects rs1_d as the halt code on an ebreak word
    localparam int negate_bit = 15;

    // ALU operation codes
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sll = 3'd1;
    localparam logic [2:0] alu_slt = 3'd2;
    localparam logic [2:0] alu_eq  = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;
    localparam logic [2:0] alu_sr  = 3'd5;
    localparam logic [2:0] alu_or  = 3'd6;
    localparam logic [2:0] alu_and = 3'd7;

    // next pc selection
    localparam logic [1:0] pc_zero = 2'b00;
    localparam logic [1:0] pc_snpc = 2'b01;
    localparam logic [1:0] pc_inpc = 2'b10;
    localparam logic [1:0] pc_reg  = 2'b11;

    // operand pair selection, named after {var1, var2}
    localparam logic [1:0] opsel_imm     = 2'b00;
    localparam logic [1:0] opsel_pc_imm  = 2'b01;
    localparam logic [1:0] opsel_rs1_rs2 = 2'b10;
    localparam logic [1:0] opsel_rs1_imm = 2'b11;

    localparam logic [31:0] halt_default_code = 32'd9;

endpackage
